/* verilog/bp_pkg.sv */
package bp_pkg;

  // Predictor geometry
  localparam int unsigned GH_BITS      = 8;
  localparam int unsigned PHT_BITS     = 10;
  localparam int unsigned BTB_BITS     = 8;
  localparam int unsigned PHT_ENTRIES  = 1 << PHT_BITS;
  localparam int unsigned BTB_ENTRIES  = 1 << BTB_BITS;

  // Upper PC bits above the index and the byte offset
  localparam int unsigned BTB_TAG_BITS = 32 - 2 - BTB_BITS;

  typedef logic [GH_BITS-1:0]      ghr_t;
  typedef logic [PHT_BITS-1:0]     pht_index_t;
  typedef logic [BTB_BITS-1:0]     btb_index_t;
  typedef logic [BTB_TAG_BITS-1:0] btb_tag_t;

  // Two-bit saturating counter, MSB is the taken bit
  typedef logic [1:0] counter_t;

  localparam counter_t COUNTER_INIT = 2'd1;  // Weakly not-taken
  localparam counter_t COUNTER_MAX  = 2'd3;
  localparam counter_t COUNTER_MIN  = 2'd0;

endpackage

/* verilog/bp_apb_pkg.sv */
package bp_apb_pkg;

  localparam int unsigned APB_ADDR_BITS = 8;
  localparam int unsigned APB_DATA_BITS = 32;

  // Width of every statistics counter
  localparam int unsigned STAT_BITS     = 32;

  // Register map, byte addresses
  typedef enum logic [APB_ADDR_BITS-1:0] {
    REG_PREDICTIONS = 8'h00,  // Used predictions
    REG_TRAINS      = 8'h04,  // Training events
    REG_TAKEN       = 8'h08,  // Taken trainings
    REG_RECOVERIES  = 8'h0C,  // Mispredict recoveries
    REG_CONTROL     = 8'h10   // Bit 0 clears all counters
  } stat_reg_e;

endpackage

/* verilog/pattern_history_table.sv */
`timescale 1ns/1ps

module pattern_history_table (
  input  logic                clock,
  input  logic                reset,
  input  bp_pkg::pht_index_t  read_index_i,
  output bp_pkg::counter_t    read_counter_o,
  input  logic                train_valid_i,
  input  bp_pkg::pht_index_t  train_index_i,
  input  logic                train_taken_i
);

  import bp_pkg::*;

  counter_t pht_mem [PHT_ENTRIES];
  counter_t train_counter;
  counter_t train_next;

  // Asynchronous predict read
  assign read_counter_o = pht_mem[read_index_i];

  // Saturating update of the trained entry
  always_comb begin
    train_counter = pht_mem[train_index_i];
    if (train_taken_i) begin
      if (train_counter == COUNTER_MAX) begin
        train_next = train_counter;
      end else begin
        train_next = train_counter + counter_t'(1);
      end
    end else begin
      if (train_counter == COUNTER_MIN) begin
        train_next = train_counter;
      end else begin
        train_next = train_counter - counter_t'(1);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < PHT_ENTRIES; i++) begin
        pht_mem[i] <= COUNTER_INIT;  // Every branch starts weakly not-taken
      end
    end else if (train_valid_i) begin
      pht_mem[train_index_i] <= train_next;
    end
  end

endmodule

/* verilog/branch_target_buffer.sv */
`timescale 1ns/1ps

module branch_target_buffer (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] lookup_pc_i,
  output logic        hit_o,
  output logic [31:0] target_o,
  input  logic        train_valid_i,  // Taken trainings only
  input  logic [31:0] train_pc_i,
  input  logic [31:0] train_target_i
);

  import bp_pkg::*;

  logic [BTB_ENTRIES-1:0] entry_valid;
  btb_tag_t               tag_mem    [BTB_ENTRIES];
  logic [31:0]            target_mem [BTB_ENTRIES];

  btb_index_t lookup_index;
  btb_tag_t   lookup_tag;
  btb_index_t train_index;
  btb_tag_t   train_tag;

  // PC split: byte offset, index, tag above it
  assign lookup_index = lookup_pc_i[2 +: BTB_BITS];
  assign lookup_tag   = lookup_pc_i[2 + BTB_BITS +: BTB_TAG_BITS];
  assign train_index  = train_pc_i[2 +: BTB_BITS];
  assign train_tag    = train_pc_i[2 + BTB_BITS +: BTB_TAG_BITS];

  assign hit_o    = entry_valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
  assign target_o = target_mem[lookup_index];

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid <= '0;
    end else if (train_valid_i) begin
      entry_valid[train_index] <= 1'b1;
    end
  end

  // Direct overwrite on every taken training
  always_ff @(posedge clock) begin
    if (train_valid_i) begin
      tag_mem[train_index]    <= train_tag;
      target_mem[train_index] <= train_target_i;
    end
  end

endmodule

/* verilog/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor (
  input  logic           clock,
  input  logic           reset,
  input  logic           predict_valid_i,
  input  logic [31:0]    predict_pc_i,
  input  logic           predict_used_i,
  output logic           predict_taken_o,
  output logic [31:0]    predict_target_o,
  output bp_pkg::ghr_t   predict_ghr_o,
  input  logic           train_valid_i,
  input  logic [31:0]    train_pc_i,
  input  logic           train_taken_i,
  input  logic [31:0]    train_target_i,
  input  bp_pkg::ghr_t   train_ghr_i,
  input  logic           recover_i,
  input  bp_pkg::ghr_t   recover_ghr_i
);

  import bp_pkg::*;

  ghr_t        ghr_q;
  pht_index_t  predict_index;
  pht_index_t  train_index;
  counter_t    predict_counter;
  logic        btb_hit;
  logic [31:0] btb_target;

  // gshare index, history zero-extended to the PHT width
  assign predict_index = predict_pc_i[2 +: PHT_BITS] ^ pht_index_t'(ghr_q);
  assign train_index   = train_pc_i[2 +: PHT_BITS] ^ pht_index_t'(train_ghr_i);

  assign predict_taken_o  = predict_valid_i & predict_counter[1];
  assign predict_target_o = (predict_taken_o && btb_hit) ? btb_target : 32'h0;
  assign predict_ghr_o    = ghr_q;

  // Recovery overrides a shift in the same cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      ghr_q <= '0;
    end else if (recover_i) begin
      ghr_q <= recover_ghr_i;
    end else if (predict_valid_i && predict_used_i) begin
      ghr_q <= {ghr_q[GH_BITS-2:0], predict_taken_o};
    end
  end

  pattern_history_table u_pht (
    .clock          (clock),
    .reset          (reset),
    .read_index_i   (predict_index),
    .read_counter_o (predict_counter),
    .train_valid_i  (train_valid_i),
    .train_index_i  (train_index),
    .train_taken_i  (train_taken_i)
  );

  branch_target_buffer u_btb (
    .clock          (clock),
    .reset          (reset),
    .lookup_pc_i    (predict_pc_i),
    .hit_o          (btb_hit),
    .target_o       (btb_target),
    .train_valid_i  (train_valid_i & train_taken_i),  // Allocate on taken only
    .train_pc_i     (train_pc_i),
    .train_target_i (train_target_i)
  );

endmodule

/* verilog/bp_stats_apb.sv */
`timescale 1ns/1ps

module bp_stats_apb (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  predict_event_i,
  input  logic                                  train_event_i,
  input  logic                                  taken_event_i,
  input  logic                                  recover_event_i,
  input  logic                                  psel_i,
  input  logic                                  penable_i,
  input  logic                                  pwrite_i,
  input  logic [bp_apb_pkg::APB_ADDR_BITS-1:0]  paddr_i,
  input  logic [bp_apb_pkg::APB_DATA_BITS-1:0]  pwdata_i,
  output logic [bp_apb_pkg::APB_DATA_BITS-1:0]  prdata_o,
  output logic                                  pready_o,
  output logic                                  pslverr_o
);

  import bp_apb_pkg::*;

  logic [STAT_BITS-1:0] stat_count [4];
  logic [3:0]           stat_event;
  logic                 access;
  logic                 addr_mapped;
  logic                 addr_counter;
  logic                 clear;

  // Same order as the register map
  assign stat_event = {recover_event_i, taken_event_i, train_event_i, predict_event_i};

  assign access = psel_i & penable_i;
  assign clear  = access && pwrite_i && (paddr_i == REG_CONTROL) && pwdata_i[0];

  always_comb begin
    addr_mapped  = 1'b1;
    addr_counter = 1'b1;
    prdata_o     = '0;
    case (paddr_i)
      REG_PREDICTIONS: prdata_o = stat_count[0];
      REG_TRAINS:      prdata_o = stat_count[1];
      REG_TAKEN:       prdata_o = stat_count[2];
      REG_RECOVERIES:  prdata_o = stat_count[3];
      REG_CONTROL: begin
        addr_counter = 1'b0;  // Reads as zero
      end
      default: begin
        addr_mapped  = 1'b0;
        addr_counter = 1'b0;
      end
    endcase
  end

  assign pready_o  = 1'b1;  // No wait states
  assign pslverr_o = access & (~addr_mapped | (pwrite_i & addr_counter));

  // Wrapping counters, clear beats a same-cycle increment
  always_ff @(posedge clock) begin
    if (reset || clear) begin
      for (int i = 0; i < 4; i++) begin
        stat_count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (stat_event[i]) begin
          stat_count[i] <= stat_count[i] + STAT_BITS'(1);
        end
      end
    end
  end

endmodule

/* verilog/bp_subsystem.sv */
`timescale 1ns/1ps

module bp_subsystem (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  predict_valid_i,
  input  logic [31:0]                           predict_pc_i,
  input  logic                                  predict_used_i,
  output logic                                  predict_taken_o,
  output logic [31:0]                           predict_target_o,
  output bp_pkg::ghr_t                          predict_ghr_o,
  input  logic                                  train_valid_i,
  input  logic [31:0]                           train_pc_i,
  input  logic                                  train_taken_i,
  input  logic [31:0]                           train_target_i,
  input  bp_pkg::ghr_t                          train_ghr_i,
  input  logic                                  recover_i,
  input  bp_pkg::ghr_t                          recover_ghr_i,
  input  logic                                  psel_i,
  input  logic                                  penable_i,
  input  logic                                  pwrite_i,
  input  logic [bp_apb_pkg::APB_ADDR_BITS-1:0]  paddr_i,
  input  logic [bp_apb_pkg::APB_DATA_BITS-1:0]  pwdata_i,
  output logic [bp_apb_pkg::APB_DATA_BITS-1:0]  prdata_o,
  output logic                                  pready_o,
  output logic                                  pslverr_o
);

  logic predict_event;
  logic train_event;
  logic taken_event;
  logic recover_event;

  assign predict_event = predict_valid_i & predict_used_i;  // Only used predictions count
  assign train_event   = train_valid_i;
  assign taken_event   = train_valid_i & train_taken_i;
  assign recover_event = recover_i;

  branch_predictor u_branch_predictor (
    .clock            (clock),
    .reset            (reset),
    .predict_valid_i  (predict_valid_i),
    .predict_pc_i     (predict_pc_i),
    .predict_used_i   (predict_used_i),
    .predict_taken_o  (predict_taken_o),
    .predict_target_o (predict_target_o),
    .predict_ghr_o    (predict_ghr_o),
    .train_valid_i    (train_valid_i),
    .train_pc_i       (train_pc_i),
    .train_taken_i    (train_taken_i),
    .train_target_i   (train_target_i),
    .train_ghr_i      (train_ghr_i),
    .recover_i        (recover_i),
    .recover_ghr_i    (recover_ghr_i)
  );

  bp_stats_apb u_bp_stats_apb (
    .clock           (clock),
    .reset           (reset),
    .predict_event_i (predict_event),
    .train_event_i   (train_event),
    .taken_event_i   (taken_event),
    .recover_event_i (recover_event),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .paddr_i         (paddr_i),
    .pwdata_i        (pwdata_i),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .pslverr_o       (pslverr_o)
  );

endmodule

/* bench/bp_subsystem_tb.sv */
`timescale 1ns/1ps

module bp_subsystem_tb;

  import bp_pkg::*;
  import bp_apb_pkg::*;

  logic        clock;
  logic        reset;
  logic        predict_valid_i;
  logic [31:0] predict_pc_i;
  logic        predict_used_i;
  logic        predict_taken_o;
  logic [31:0] predict_target_o;
  ghr_t        predict_ghr_o;
  logic        train_valid_i;
  logic [31:0] train_pc_i;
  logic        train_taken_i;
  logic [31:0] train_target_i;
  ghr_t        train_ghr_i;
  logic        recover_i;
  ghr_t        recover_ghr_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [7:0]  paddr_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        pslverr_o;

  // Reference model state
  logic [1:0]  pht_model [PHT_ENTRIES];
  logic        btb_valid [BTB_ENTRIES];
  logic [21:0] btb_tag [BTB_ENTRIES];
  logic [31:0] btb_target [BTB_ENTRIES];
  logic [7:0]  ghr_model;
  logic [31:0] pred_count;
  logic [31:0] train_count;
  logic [31:0] taken_count;
  logic [31:0] recover_count;

  integer seed;
  int     check_count;
  int     error_count;
  int     timeout_count;

  bp_subsystem u_bp_subsystem (.*);

  always #50 clock = ~clock;

  // Without a valid request there is never a taken prediction
  assert property (@(posedge clock) disable iff (reset) !predict_valid_i |-> !predict_taken_o)
    else begin
      $display("Fail %0t: predict_taken_o high without predict_valid_i", $time);
      error_count++;
    end

  // gshare slot: word index of the PC XOR the history
  function automatic logic [9:0] pht_slot(input logic [31:0] pc, input logic [7:0] hist);
    return pc[11:2] ^ {2'b00, hist};
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  // Inputs change 10 ns after the edge, strobes drop unless set again
  task automatic start_cycle();
    @(posedge clock);
    #10;
    predict_valid_i = 1'b0;
    predict_used_i  = 1'b0;
    train_valid_i   = 1'b0;
    train_taken_i   = 1'b0;
    recover_i       = 1'b0;
  endtask

  // Check outputs mid-cycle, then advance the model to the coming edge
  task automatic finish_cycle();
    logic [9:0]  slot;
    logic [7:0]  entry;
    logic        exp_taken;
    logic [31:0] exp_target;
    #40;
    slot       = pht_slot(predict_pc_i, ghr_model);
    entry      = predict_pc_i[9:2];
    exp_taken  = predict_valid_i & pht_model[slot][1];
    exp_target = 32'd0;
    if (exp_taken && btb_valid[entry] && btb_tag[entry] == predict_pc_i[31:10]) begin
      exp_target = btb_target[entry];
    end
    compare_value("predict_taken_o", 32'(predict_taken_o), 32'(exp_taken));
    compare_value("predict_target_o", predict_target_o, exp_target);
    compare_value("predict_ghr_o", 32'(predict_ghr_o), 32'(ghr_model));
    if (train_valid_i) begin
      slot = pht_slot(train_pc_i, train_ghr_i);
      if (train_taken_i && pht_model[slot] != 2'd3) begin
        pht_model[slot] = pht_model[slot] + 2'd1;
      end else if (!train_taken_i && pht_model[slot] != 2'd0) begin
        pht_model[slot] = pht_model[slot] - 2'd1;
      end
      train_count = train_count + 32'd1;
      if (train_taken_i) begin
        entry             = train_pc_i[9:2];
        btb_valid[entry]  = 1'b1;
        btb_tag[entry]    = train_pc_i[31:10];
        btb_target[entry] = train_target_i;
        taken_count       = taken_count + 32'd1;
      end
    end
    if (predict_valid_i && predict_used_i) begin
      pred_count = pred_count + 32'd1;
    end
    if (recover_i) begin
      ghr_model     = recover_ghr_i;  // Wins over the shift
      recover_count = recover_count + 32'd1;
    end else if (predict_valid_i && predict_used_i) begin
      ghr_model = {ghr_model[6:0], exp_taken};
    end
  endtask

  task automatic train_branch(input logic [31:0] pc, input logic taken,
                              input logic [31:0] target, input logic [7:0] hist);
    start_cycle();
    train_valid_i  = 1'b1;
    train_pc_i     = pc;
    train_taken_i  = taken;
    train_target_i = target;
    train_ghr_i    = hist;
    finish_cycle();
  endtask

  task automatic request_prediction(input logic [31:0] pc, input logic used,
                                    input logic recover, input logic [7:0] rhist);
    start_cycle();
    predict_valid_i = 1'b1;
    predict_pc_i    = pc;
    predict_used_i  = used;
    recover_i       = recover;
    recover_ghr_i   = rhist;
    finish_cycle();
  endtask

  // Sample point of the access phase, retried while pready is low
  task automatic wait_ready();
    int waited;
    waited = 0;
    #40;
    while (pready_o !== 1'b1 && waited < 16) begin
      @(posedge clock);
      #50;
      waited++;
    end
    if (pready_o !== 1'b1) begin
      $display("Timeout at %0t: APB slave never raised pready", $time);
      timeout_count++;
    end
  endtask

  task automatic expect_register(input logic [7:0] addr, input logic [31:0] exp_data,
                                 input logic exp_err);
    start_cycle();
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = addr;
    start_cycle();
    penable_i = 1'b1;
    wait_ready();
    compare_value("pslverr_o", 32'(pslverr_o), 32'(exp_err));
    if (!exp_err) begin
      compare_value("prdata_o", prdata_o, exp_data);
    end
    start_cycle();
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic write_register(input logic [7:0] addr, input logic [31:0] data,
                                input logic exp_err);
    start_cycle();
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = data;
    start_cycle();
    penable_i = 1'b1;
    wait_ready();
    compare_value("pslverr_o", 32'(pslverr_o), 32'(exp_err));
    start_cycle();
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic check_stats();
    expect_register(REG_PREDICTIONS, pred_count, 1'b0);
    expect_register(REG_TRAINS, train_count, 1'b0);
    expect_register(REG_TAKEN, taken_count, 1'b0);
    expect_register(REG_RECOVERIES, recover_count, 1'b0);
  endtask

  initial begin
    logic [31:0] pc_a;
    logic [31:0] pc_b;
    logic [31:0] pc_c;
    logic [31:0] target_a;
    logic [31:0] rnd;
    seed            = 84677;
    clock           = 1'b0;
    reset           = 1'b1;
    predict_valid_i = 1'b0;
    predict_pc_i    = '0;
    predict_used_i  = 1'b0;
    train_valid_i   = 1'b0;
    train_pc_i      = '0;
    train_taken_i   = 1'b0;
    train_target_i  = '0;
    train_ghr_i     = '0;
    recover_i       = 1'b0;
    recover_ghr_i   = '0;
    psel_i          = 1'b0;
    penable_i       = 1'b0;
    pwrite_i        = 1'b0;
    paddr_i         = '0;
    pwdata_i        = '0;
    for (int i = 0; i < PHT_ENTRIES; i++) begin
      pht_model[i] = COUNTER_INIT;
    end
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      btb_valid[i]  = 1'b0;
      btb_tag[i]    = '0;
      btb_target[i] = '0;
    end
    ghr_model     = '0;
    pred_count    = '0;
    train_count   = '0;
    taken_count   = '0;
    recover_count = '0;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    repeat (3) @(posedge clock);
    #10 reset = 1'b0;

    // Cold state
    pc_c = $random(seed);
    request_prediction(pc_c, 1'b0, 1'b0, 8'h00);
    check_stats();

    // One taken training, then a hit
    pc_a       = $random(seed);
    pc_a[1:0]  = 2'b00;
    target_a   = $random(seed);
    train_branch(pc_a, 1'b1, target_a, 8'h00);
    request_prediction(pc_a, 1'b0, 1'b0, 8'h00);

    // Saturation at both ends, on a slot apart from pc_a
    pc_b      = $random(seed);
    pc_b[1:0] = 2'b00;
    if (pc_b[11:2] == pc_a[11:2]) begin
      pc_b[2] = ~pc_b[2];
    end
    repeat (3) train_branch(pc_b, 1'b0, 32'h0, 8'h00);
    train_branch(pc_b, 1'b1, $random(seed), 8'h00);
    request_prediction(pc_b, 1'b0, 1'b0, 8'h00);
    repeat (4) train_branch(pc_b, 1'b1, $random(seed), 8'h00);
    train_branch(pc_b, 1'b0, 32'h0, 8'h00);
    request_prediction(pc_b, 1'b0, 1'b0, 8'h00);

    // Same indices, different tag
    pc_c = pc_a ^ 32'h0000_1000;
    request_prediction(pc_c, 1'b0, 1'b0, 8'h00);

    // History shift, then recovery beside a used prediction
    request_prediction(pc_a, 1'b1, 1'b0, 8'h00);
    request_prediction(pc_b, 1'b1, 1'b0, 8'h00);
    request_prediction(pc_a, 1'b1, 1'b1, 8'hA5);
    request_prediction(pc_c, 1'b0, 1'b0, 8'h00);

    // Mixed traffic with history snapshots
    for (int n = 0; n < 24; n++) begin
      start_cycle();
      rnd             = $random(seed);
      predict_valid_i = rnd[0];
      predict_used_i  = rnd[1];
      predict_pc_i    = rnd[2] ? pc_a : pc_b;
      train_valid_i   = rnd[3];
      train_pc_i      = rnd[4] ? pc_a : pc_b;
      train_taken_i   = rnd[5];
      train_target_i  = $random(seed);
      train_ghr_i     = ghr_model;
      recover_i       = (rnd[7:6] == 2'b00);
      recover_ghr_i   = rnd[15:8];
      finish_cycle();
    end

    // Statistics, clear and slave errors
    check_stats();
    write_register(REG_CONTROL, 32'h1, 1'b0);
    pred_count    = '0;
    train_count   = '0;
    taken_count   = '0;
    recover_count = '0;
    check_stats();
    expect_register(8'h14, 32'h0, 1'b1);
    write_register(REG_TRAINS, 32'h55, 1'b1);
    expect_register(REG_CONTROL, 32'h0, 1'b0);
    check_stats();

    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* src.f */
verilog/bp_pkg.sv
verilog/bp_apb_pkg.sv
verilog/pattern_history_table.sv
verilog/branch_target_buffer.sv
verilog/branch_predictor.sv
verilog/bp_stats_apb.sv
verilog/bp_subsystem.sv
bench/bp_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module bp_subsystem_tb \
  -Mdir obj_dir -o sim_bp_subsystem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_bp_subsystem)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qF "*** TEST PASSED ***"; then
  exit 0
fi
exit 1
